// File: Makefile
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top -Mdir obj_dir

run: obj_dir/Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: dv/sample_vectors.txt
# B <flags> <tlast> <tdata as eight words, bits 255:224 first>  flags: 1 clear and new test, 2 random tready
# E <value>  next expected result_value_o
B 1 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 00001234 56780000 00003930 00000000
E 12345678
B 0 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 0 00000000 00000000 00000000 00000000 0000cafe f00d0000 00003930 00000000
B 0 1 01234567 89abcdef 01234567 89abcdef 01234567 89abcdef 01234567 89abcdef
E cafef00d
B 1 0 ffff0000 00000000 11400000 00000000 00000800 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 0000dead beef0000 00003930 00000000
B 0 0 ffff0000 00000000 06400000 00000000 00000008 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 0000dead beef0000 00003930 00000000
B 0 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 0000dead beef0000 00003039 00000000
B 0 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 00000bad c0de0000 00003930 00000000
E 0badc0de
B 3 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 1 00000000 00000000 00000000 00000000 00001111 11110000 00003930 00000000
E 11111111
B 0 0 ffff0000 00000000 11400000 00000000 00000008 00000000 00000000 00000000
B 0 0 00000000 00000000 00000000 00000000 00002222 22220000 00003930 00000000
B 0 1 01234567 89abcdef 01234567 89abcdef 01234567 89abcdef 01234567 89abcdef
E 22222222

// File: dv/tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
	parameter int DATA_WIDTH = 256,
	parameter int USER_WIDTH = 128
) (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  logic [DATA_WIDTH-1:0]   s_tdata_i,
	input  logic [DATA_WIDTH/8-1:0] s_tkeep_i,
	input  logic [USER_WIDTH-1:0]   s_tuser_i,
	input  logic                    s_tvalid_i,
	input  logic                    s_tlast_i,
	input  logic                    m_tready_i,
	input  logic                    clear_i,
	input  logic                    dut_s_tready_i,
	input  logic [DATA_WIDTH-1:0]   dut_m_tdata_i,
	input  logic [DATA_WIDTH/8-1:0] dut_m_tkeep_i,
	input  logic [USER_WIDTH-1:0]   dut_m_tuser_i,
	input  logic                    dut_m_tvalid_i,
	input  logic                    dut_m_tlast_i,
	input  logic                    result_valid_i,
	input  logic [31:0]             result_value_i,
	input  logic [31:0]             sample_count_i,
	input  logic [31:0]             pkt_count_i,
	input  logic                    exp_push_i,
	input  logic [31:0]             exp_value_i,
	input  logic                    test_end_i,
	input  int                      test_num_i,
	input  logic                    run_end_i,
	output int                      pending_o,
	output int                      error_count_o
);

	logic [31:0] exp_q[$];
	logic [31:0] exp_pkt = '0;
	logic [31:0] pulses = '0;
	logic        after_clear = 1'b1;
	int          checks = 0;
	int          test_mark = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          total_exp = 0;
	int          total_pulses = 0;

	initial begin
		pending_o = 0;
		error_count_o = 0;
	end

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] expected);
		checks++;
		if (got !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got,
				expected);
			error_count_o++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		error_count_o++;
	endtask

	// outputs here reflect the last edge, inputs are the ones for the next
	always @(negedge clk_i) begin
		logic [31:0] expected;
		if (rstn_i) begin
			check_value("m_axis_tdata_o", dut_m_tdata_i, s_tdata_i);
			check_value("m_axis_tkeep_o", dut_m_tkeep_i, s_tkeep_i);
			check_value("m_axis_tuser_o", dut_m_tuser_i, s_tuser_i);
			check_value("m_axis_tvalid_o", dut_m_tvalid_i, s_tvalid_i);
			check_value("m_axis_tlast_o", dut_m_tlast_i, s_tlast_i);
			check_value("s_axis_tready_o", dut_s_tready_i, m_tready_i);
			check_value("pkt_count_o", pkt_count_i, exp_pkt);
			if (after_clear) begin
				check_value("sample_count_o", sample_count_i, 0);
				check_value("result_value_o", result_value_i, 0);
			end
			after_clear = 1'b0;
			if (result_valid_i) begin
				total_pulses++;
				if (exp_q.size() == 0) begin
					report_problem("result_valid_o pulsed while no result was expected");
				end else begin
					expected = exp_q.pop_front();
					pulses++;
					check_value("result_value_o", result_value_i, expected);
					check_value("sample_count_o", sample_count_i, pulses);
				end
			end
		end
		// reference state for the coming edge
		if (!rstn_i || clear_i) begin
			exp_pkt = '0;
			pulses = '0;
			after_clear = 1'b1;
		end else if (s_tvalid_i && m_tready_i && s_tlast_i) begin
			exp_pkt++;
		end
		if (exp_push_i) begin
			exp_q.push_back(exp_value_i);
			total_exp++;
		end
		if (test_end_i) begin
			tests_run++;
			if (error_count_o == test_mark) begin
				$display("test %0d: passed", test_num_i);
			end else begin
				tests_failed++;
				$display("test %0d: failed with %0d errors", test_num_i,
					error_count_o - test_mark);
			end
			test_mark = error_count_o;
		end
		if (run_end_i) begin
			if (total_pulses != total_exp) begin
				report_problem($sformatf("saw %0d result pulses for %0d expected results",
					total_pulses, total_exp));
			end
			$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run,
				tests_failed, checks, error_count_o);
		end
		pending_o = exp_q.size();
	end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic rstn_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// release lands just after an edge, like the other stimulus
	initial begin
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rstn_o = 1'b1;
	end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;

	localparam int DATA_WIDTH = 256;
	localparam int USER_WIDTH = 128;

	logic                    clk;
	logic                    rstn;
	logic [DATA_WIDTH-1:0]   s_tdata = '0;
	logic [DATA_WIDTH/8-1:0] s_tkeep = '1;
	logic [USER_WIDTH-1:0]   s_tuser = '0;
	logic                    s_tvalid = 1'b0;
	logic                    s_tlast = 1'b0;
	logic                    m_tready = 1'b1;
	logic                    clear = 1'b0;
	logic                    s_tready;
	logic [DATA_WIDTH-1:0]   m_tdata;
	logic [DATA_WIDTH/8-1:0] m_tkeep;
	logic [USER_WIDTH-1:0]   m_tuser;
	logic                    m_tvalid;
	logic                    m_tlast;
	logic                    result_valid;
	logic [31:0]             result_value;
	logic [31:0]             sample_count;
	logic [31:0]             pkt_count;

	logic        exp_push = 1'b0;
	logic [31:0] exp_value = '0;
	logic        test_end = 1'b0;
	logic        run_end = 1'b0;
	int          test_num = 0;
	int          pending;
	int          err_count;
	logic        rand_ready = 1'b0;
	logic [31:0] lfsr_state = 32'h49b317ba;
	int          beats_sent = 0;
	int          bad_lines = 0;
	int          watchdog_cycles = 100;

	// one entry per vector line, kind is B or E
	byte             kind_q[$];
	logic [7:0]      ctl_q[$];
	logic            last_q[$];
	logic [DATA_WIDTH-1:0] data_q[$];

	tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) u_clk_gen (
		.clk_o  (clk),
		.rstn_o (rstn)
	);

	udp_sample_top #(
		.DATA_WIDTH      (DATA_WIDTH),
		.USER_WIDTH      (USER_WIDTH),
		.FIFO_DEPTH_BITS (3)
	) UUT (
		.axis_aclk       (clk),
		.cf_rstn         (rstn),
		.s_axis_tdata_i  (s_tdata),
		.s_axis_tkeep_i  (s_tkeep),
		.s_axis_tuser_i  (s_tuser),
		.s_axis_tvalid_i (s_tvalid),
		.s_axis_tlast_i  (s_tlast),
		.m_axis_tready_i (m_tready),
		.clear_i         (clear),
		.s_axis_tready_o (s_tready),
		.m_axis_tdata_o  (m_tdata),
		.m_axis_tkeep_o  (m_tkeep),
		.m_axis_tuser_o  (m_tuser),
		.m_axis_tvalid_o (m_tvalid),
		.m_axis_tlast_o  (m_tlast),
		.result_valid_o  (result_valid),
		.result_value_o  (result_value),
		.sample_count_o  (sample_count),
		.pkt_count_o     (pkt_count)
	);

	tb_checker #(.DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH)) u_checker (
		.clk_i          (clk),
		.rstn_i         (rstn),
		.s_tdata_i      (s_tdata),
		.s_tkeep_i      (s_tkeep),
		.s_tuser_i      (s_tuser),
		.s_tvalid_i     (s_tvalid),
		.s_tlast_i      (s_tlast),
		.m_tready_i     (m_tready),
		.clear_i        (clear),
		.dut_s_tready_i (s_tready),
		.dut_m_tdata_i  (m_tdata),
		.dut_m_tkeep_i  (m_tkeep),
		.dut_m_tuser_i  (m_tuser),
		.dut_m_tvalid_i (m_tvalid),
		.dut_m_tlast_i  (m_tlast),
		.result_valid_i (result_valid),
		.result_value_i (result_value),
		.sample_count_i (sample_count),
		.pkt_count_i    (pkt_count),
		.exp_push_i     (exp_push),
		.exp_value_i    (exp_value),
		.test_end_i     (test_end),
		.test_num_i     (test_num),
		.run_end_i      (run_end),
		.pending_o      (pending),
		.error_count_o  (err_count)
	);

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	always @(posedge clk) begin
		#1;
		if (rand_ready) begin
			m_tready = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end else begin
			m_tready = 1'b1;
		end
	end

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  ctl;
		logic [7:0]  last_v;
		logic [31:0] w7, w6, w5, w4, w3, w2, w1, w0;
		fd = $fopen("dv/sample_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/sample_vectors.txt");
			bad_lines++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			if (line[0] == "B") begin
				n = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h", ctl, last_v,
					w7, w6, w5, w4, w3, w2, w1, w0);
			end else begin
				n = $sscanf(line, "E %h", w0) + 9;
				ctl = '0;
				last_v = '0;
			end
			if (n != 10 || (line[0] != "B" && line[0] != "E")) begin
				$display("malformed vector line: %s", line);
				bad_lines++;
				continue;
			end
			kind_q.push_back(line[0]);
			ctl_q.push_back(ctl);
			last_q.push_back(last_v[0]);
			data_q.push_back((line[0] == "B") ? {w7, w6, w5, w4, w3, w2, w1, w0}
				: {224'h0, w0});
		end
		$fclose(fd);
	endtask

	// holds the beat until a rising edge sees tready high
	task automatic drive_beat(input logic last, input logic [DATA_WIDTH-1:0] data);
		logic taken;
		taken = 1'b0;
		s_tvalid = 1'b1;
		s_tdata = data;
		s_tlast = last;
		s_tkeep = ~(DATA_WIDTH/8)'(beats_sent);
		s_tuser = {96'h0, beats_sent};
		while (!taken) begin
			@(posedge clk);
			taken = m_tready;
		end
		#1;
		beats_sent++;
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
	endtask

	task automatic send_expect(input logic [31:0] value);
		exp_value = value;
		exp_push = 1'b1;
		@(posedge clk);
		#1;
		exp_push = 1'b0;
	endtask

	// under back-pressure a result can come back before its frame's last beat,
	// so the expected values of a whole test are queued ahead of its first beat
	task automatic queue_test_expects(input int first);
		int j;
		j = first + 1;
		while (j < kind_q.size() && !(kind_q[j] == "B" && ctl_q[j][0])) begin
			if (kind_q[j] == "E") begin
				send_expect(data_q[j][31:0]);
			end
			j++;
		end
	endtask

	// let queued results drain, leave room for a stray pulse, then report
	task automatic finish_test();
		while (pending != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		#1;
		test_end = 1'b1;
		@(posedge clk);
		#1;
		test_end = 1'b0;
	endtask

	initial begin
		load_vectors();
		watchdog_cycles = 20 * kind_q.size() + 100;
		wait (rstn);
		@(posedge clk);
		#1;
		foreach (kind_q[i]) begin
			if (kind_q[i] == "B") begin
				if (ctl_q[i][0]) begin
					if (test_num > 0) begin
						finish_test();
					end
					test_num++;
					clear = 1'b1;
					@(posedge clk);
					rand_ready = ctl_q[i][1];
					#1;
					clear = 1'b0;
					queue_test_expects(i);
				end
				drive_beat(last_q[i], data_q[i]);
			end
		end
		finish_test();
		run_end = 1'b1;
		@(posedge clk);
		#1;
		run_end = 1'b0;
		if (err_count == 0 && bad_lines == 0 && test_num > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#1;
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout after %0d cycles, the run did not complete", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
src/net_hdr_pkg.sv
src/sample_pkg.sv
src/udp_sample_parser.sv
src/sample_fifo.sv
src/sample_sink.sv
src/udp_sample_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: src/net_hdr_pkg.sv
package net_hdr_pkg;

	// bit offsets inside beat 0 of the frame
	localparam int ETH_TYPE_POS = 96;
	localparam int IP_PROTO_POS = 184;

	// bit offsets inside beat 1 of the frame
	localparam int UDP_DST_PORT_POS = 32;
	localparam int USER_DATA_POS    = 80;

	// ethertype as it sits on the bus, bytes swapped
	localparam logic [15:0] IP_TYPE = 16'h0008;

	localparam logic [7:0] UDP_PROTO = 8'h11;

	// compared after swapping the port bytes back to host order
	localparam logic [15:0] UDP_PORT_TRIG = 16'd12345;

endpackage

// File: src/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
	parameter int  FIFO_DEPTH_BITS = 3,
	parameter type entry_t         = logic [31:0]
) (
	input  logic   axis_aclk,
	input  logic   cf_rstn,
	input  logic   push_i,
	input  entry_t push_data_i,
	input  logic   pop_i,
	output entry_t head_o,
	output logic   empty_o
);

	localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

	entry_t                     mem [DEPTH];
	logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [FIFO_DEPTH_BITS:0]   count;
	logic                       full;
	logic                       do_push;
	logic                       do_pop;

	assign full    = (count == (FIFO_DEPTH_BITS+1)'(DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full;
	assign do_pop  = pop_i && !empty_o;

	// fall-through, the oldest entry is always on the output
	assign head_o = mem[rd_ptr];

	always_ff @(posedge axis_aclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// writer rate is bounded by frame length and the reader drains every cycle
	assert property (@(posedge axis_aclk) disable iff (!cf_rstn) push_i |-> !full);
	assert property (@(posedge axis_aclk) disable iff (!cf_rstn) pop_i |-> !empty_o);

endmodule

// File: src/sample_pkg.sv
package sample_pkg;

	// width of one user value taken from a frame
	localparam int SAMPLE_WIDTH = 32;

	// counter width, top bit is the sticky overflow where one is kept
	localparam int COUNT_WIDTH = 32;

	// one user value as carried through the FIFO
	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

// File: src/sample_sink.sv
`timescale 1ns/1ns

module sample_sink (
	input  logic                axis_aclk,
	input  logic                cf_rstn,
	input  logic                empty_i,
	input  sample_pkg::sample_t head_i,
	input  logic                clear_i,
	output logic                pop_o,
	output logic                result_valid_o,
	output sample_pkg::sample_t result_value_o,
	output sample_pkg::count_t  sample_count_o
);

	// drain one entry whenever there is one
	assign pop_o = !empty_i;

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			result_valid_o <= 1'b0;
		end else begin
			// a sample popped during clear is dropped with the old results
			result_valid_o <= pop_o && !clear_i;
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			result_value_o <= '0;
			sample_count_o <= '0;
		end else if (clear_i) begin
			result_value_o <= '0;
			sample_count_o <= '0;
		end else if (pop_o) begin
			result_value_o <= head_i;
			sample_count_o <= sample_count_o + 1'b1;
		end
	end

endmodule

// File: src/udp_sample_parser.sv
`timescale 1ns/1ns

module udp_sample_parser #(
	parameter int DATA_WIDTH = 256
) (
	input  logic                  axis_aclk,
	input  logic                  cf_rstn,
	input  logic [DATA_WIDTH-1:0] s_axis_tdata_i,
	input  logic                  s_axis_tvalid_i,
	input  logic                  s_axis_tready_i,
	input  logic                  s_axis_tlast_i,
	input  logic                  clear_i,
	output logic                  push_o,
	output sample_pkg::sample_t   push_data_o,
	output sample_pkg::count_t    pkt_count_o
);

	import net_hdr_pkg::*;
	import sample_pkg::*;

	// beat index in the frame, stops at 2 once the header beats are past
	logic [1:0]  beat_cnt;
	logic        ip_hit;
	logic        udp_hit;
	logic        accept;
	logic        hdr_beat1;
	logic [15:0] eth_type;
	logic [7:0]  ip_proto;
	logic [15:0] dst_port;
	logic        port_hit;
	count_t      pkt_next;

	assign accept    = s_axis_tvalid_i && s_axis_tready_i;
	assign hdr_beat1 = accept && (beat_cnt == 2'd1);

	assign eth_type = s_axis_tdata_i[ETH_TYPE_POS +: 16];
	assign ip_proto = s_axis_tdata_i[IP_PROTO_POS +: 8];

	// port arrives in network byte order
	assign dst_port = {s_axis_tdata_i[UDP_DST_PORT_POS +: 8],
		s_axis_tdata_i[UDP_DST_PORT_POS+8 +: 8]};
	assign port_hit = (dst_port == UDP_PORT_TRIG);

	// header flags live from beat 0 until the tlast beat
	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			beat_cnt <= 2'd0;
			ip_hit   <= 1'b0;
			udp_hit  <= 1'b0;
		end else if (accept) begin
			if (s_axis_tlast_i) begin
				beat_cnt <= 2'd0;
				ip_hit   <= 1'b0;
				udp_hit  <= 1'b0;
			end else begin
				if (beat_cnt == 2'd0) begin
					ip_hit  <= (eth_type == IP_TYPE);
					udp_hit <= (ip_proto == UDP_PROTO);
				end
				if (beat_cnt != 2'd2) begin
					beat_cnt <= beat_cnt + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			push_o <= 1'b0;
		end else begin
			push_o <= hdr_beat1 && ip_hit && udp_hit && port_hit;
		end
	end

	// value only matters in the cycle push_o is high
	always_ff @(posedge axis_aclk) begin
		if (hdr_beat1) begin
			push_data_o <= s_axis_tdata_i[USER_DATA_POS +: SAMPLE_WIDTH];
		end
	end

	// low bits count frames, carry out sets the sticky top bit
	assign pkt_next = {1'b0, pkt_count_o[COUNT_WIDTH-2:0]} + 1'b1;

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			pkt_count_o <= '0;
		end else if (clear_i) begin
			pkt_count_o <= '0;
		end else if (accept && s_axis_tlast_i) begin
			pkt_count_o <= {pkt_count_o[COUNT_WIDTH-1] | pkt_next[COUNT_WIDTH-1],
				pkt_next[COUNT_WIDTH-2:0]};
		end
	end

endmodule

// File: src/udp_sample_top.sv
`timescale 1ns/1ns

module udp_sample_top #(
	parameter int DATA_WIDTH      = 256,
	parameter int USER_WIDTH      = 128,
	parameter int FIFO_DEPTH_BITS = 3
) (
	input  logic                    axis_aclk,
	input  logic                    cf_rstn,
	input  logic [DATA_WIDTH-1:0]   s_axis_tdata_i,
	input  logic [DATA_WIDTH/8-1:0] s_axis_tkeep_i,
	input  logic [USER_WIDTH-1:0]   s_axis_tuser_i,
	input  logic                    s_axis_tvalid_i,
	input  logic                    s_axis_tlast_i,
	input  logic                    m_axis_tready_i,
	input  logic                    clear_i,
	output logic                    s_axis_tready_o,
	output logic [DATA_WIDTH-1:0]   m_axis_tdata_o,
	output logic [DATA_WIDTH/8-1:0] m_axis_tkeep_o,
	output logic [USER_WIDTH-1:0]   m_axis_tuser_o,
	output logic                    m_axis_tvalid_o,
	output logic                    m_axis_tlast_o,
	output logic                    result_valid_o,
	output sample_pkg::sample_t     result_value_o,
	output sample_pkg::count_t      sample_count_o,
	output sample_pkg::count_t      pkt_count_o
);

	import sample_pkg::*;

	logic    push;
	sample_t push_data;
	logic    fifo_empty;
	sample_t fifo_head;
	logic    pop;

	// stream passes through untouched
	assign m_axis_tdata_o  = s_axis_tdata_i;
	assign m_axis_tkeep_o  = s_axis_tkeep_i;
	assign m_axis_tuser_o  = s_axis_tuser_i;
	assign m_axis_tvalid_o = s_axis_tvalid_i;
	assign m_axis_tlast_o  = s_axis_tlast_i;
	assign s_axis_tready_o = m_axis_tready_i;

	udp_sample_parser #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_parser (
		.axis_aclk       (axis_aclk),
		.cf_rstn         (cf_rstn),
		.s_axis_tdata_i  (s_axis_tdata_i),
		.s_axis_tvalid_i (s_axis_tvalid_i),
		.s_axis_tready_i (m_axis_tready_i),
		.s_axis_tlast_i  (s_axis_tlast_i),
		.clear_i         (clear_i),
		.push_o          (push),
		.push_data_o     (push_data),
		.pkt_count_o     (pkt_count_o)
	);

	sample_fifo #(
		.FIFO_DEPTH_BITS (FIFO_DEPTH_BITS),
		.entry_t         (sample_t)
	) u_fifo (
		.axis_aclk   (axis_aclk),
		.cf_rstn     (cf_rstn),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (pop),
		.head_o      (fifo_head),
		.empty_o     (fifo_empty)
	);

	sample_sink u_sink (
		.axis_aclk      (axis_aclk),
		.cf_rstn        (cf_rstn),
		.empty_i        (fifo_empty),
		.head_i         (fifo_head),
		.clear_i        (clear_i),
		.pop_o          (pop),
		.result_valid_o (result_valid_o),
		.result_value_o (result_value_o),
		.sample_count_o (sample_count_o)
	);

endmodule
